//--- Bender.yml
package:
  name: rv_soc

sources:
  - src/rv_soc_pkg.sv
  - src/rv_regfile.sv
  - src/rv_ramio.sv
  - src/rv_core.sv
  - src/rv_soc.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/spi_flash_model.sv
      - verif/tb_rv_soc.sv

//--- rv_soc.f
src/rv_soc_pkg.sv
src/rv_regfile.sv
src/rv_ramio.sv
src/rv_core.sv
src/rv_soc.sv
verif/tb_clk_gen.sv
verif/spi_flash_model.sv
verif/tb_rv_soc.sv

//--- src/rv_core.sv
// Multi-cycle RV32I core with SPI flash boot loader (command 3 from address 0).
// No fence, ecall, ebreak, CSRs, interrupts or misalignment traps.
// boot_bytes must be a multiple of 4; unknown opcodes and funct3 act as no-ops.
`timescale 1ns/1ps

module rv_core #(
  parameter int startup_wait = 1000,
  parameter int boot_bytes   = 1024
) (
  input  logic                 clk,
  input  logic                 rst_n,
  output logic                 enable,
  output rv_soc_pkg::wr_size_e write_type,
  output rv_soc_pkg::rd_size_e read_type,
  output logic [31:0]          address,
  output logic [31:0]          data_in,
  input  logic [31:0]          data_out,
  input  logic                 data_out_ready,
  input  logic                 busy,
  output logic                 flash_clk,
  output logic                 flash_cs,
  output logic                 flash_mosi,
  input  logic                 flash_miso
);
  import rv_soc_pkg::*;

  core_state_e state;
  core_state_e return_state;  // where st_boot_send goes when done

  // boot loader
  logic [31:0] flash_counter;
  logic        flash_phase;  // 0 = clk low half, 1 = clk high half
  logic [23:0] flash_shift;
  logic [4:0]  flash_bits;
  logic [7:0]  flash_byte;
  logic [1:0]  byte_num;
  logic [7:0]  flash_data [4];
  logic [31:0] address_next;

  // cpu
  logic [31:0] pc;
  logic [31:0] ir;
  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic [31:0] rs1_dat;
  logic [31:0] rs2_dat;
  logic [31:0] rd_wd;
  logic        rd_we;
  logic [31:0] alu_b;
  logic [31:0] alu_out;
  logic        take_branch;
  logic [31:0] jalr_target;
  rd_size_e    load_type;
  wr_size_e    store_type;
  logic        in_cpu;

  assign opcode = opcode_e'(ir[6:0]);
  assign funct3 = ir[14:12];
  assign rs1 = ir[19:15];
  assign rs2 = ir[24:20];
  assign rd = ir[11:7];

  wire [31:0] imm_u = {ir[31:12], 12'd0};
  wire [31:0] imm_i = {{20{ir[31]}}, ir[31:20]};
  wire [31:0] imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  wire [31:0] imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
  wire [31:0] imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

  assign jalr_target = (rs1_dat + imm_i) & ~32'd1;
  assign alu_b = (opcode == opc_reg) ? rs2_dat : imm_i;  // shamt is alu_b[4:0] either way

  always_comb begin
    alu_out = rs1_dat & alu_b;
    unique case (funct3)
      3'b000: begin
        if (opcode == opc_reg && ir[30]) begin
          alu_out = rs1_dat - alu_b;  // sub
        end else begin
          alu_out = rs1_dat + alu_b;
        end
      end
      3'b001: alu_out = rs1_dat << alu_b[4:0];
      3'b010: alu_out = {31'd0, $signed(rs1_dat) < $signed(alu_b)};
      3'b011: alu_out = {31'd0, rs1_dat < alu_b};
      3'b100: alu_out = rs1_dat ^ alu_b;
      3'b101: begin
        if (ir[30]) begin
          alu_out = $signed(rs1_dat) >>> alu_b[4:0];  // sra, srai
        end else begin
          alu_out = rs1_dat >> alu_b[4:0];
        end
      end
      3'b110: alu_out = rs1_dat | alu_b;
      default: ;
    endcase
  end

  always_comb begin
    unique case (funct3)
      3'b000:  take_branch = (rs1_dat == rs2_dat);
      3'b001:  take_branch = (rs1_dat != rs2_dat);
      3'b100:  take_branch = $signed(rs1_dat) < $signed(rs2_dat);
      3'b101:  take_branch = $signed(rs1_dat) >= $signed(rs2_dat);
      3'b110:  take_branch = rs1_dat < rs2_dat;
      3'b111:  take_branch = rs1_dat >= rs2_dat;
      default: take_branch = 1'b0;
    endcase
  end

  always_comb begin
    unique case (funct3)
      3'b000:  load_type = rd_byte_s;
      3'b001:  load_type = rd_half_s;
      3'b010:  load_type = rd_word;
      3'b100:  load_type = rd_byte_u;
      3'b101:  load_type = rd_half_u;
      default: load_type = rd_none;
    endcase
    unique case (funct3)
      3'b000:  store_type = wr_byte;
      3'b001:  store_type = wr_half;
      3'b010:  store_type = wr_word;
      default: store_type = wr_none;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_boot_init_power;
      return_state <= st_boot_init_power;
      enable <= 1'b0;
      write_type <= wr_none;
      read_type <= rd_none;
      address <= 32'd0;
      data_in <= 32'd0;
      flash_clk <= 1'b0;
      flash_cs <= 1'b1;
      flash_mosi <= 1'b0;
      flash_counter <= 32'd0;
      flash_phase <= 1'b0;
      flash_shift <= 24'd0;
      flash_bits <= 5'd0;
      flash_byte <= 8'd0;
      byte_num <= 2'd0;
      flash_data <= '{default: 8'd0};
      address_next <= 32'd0;
      pc <= 32'd0;
      ir <= 32'd0;
      rd_wd <= 32'd0;
      rd_we <= 1'b0;
    end else begin
      enable <= 1'b0;  // requests last one cycle
      rd_we <= 1'b0;
      unique case (state)
        st_boot_init_power: begin
          if (flash_counter >= 32'(startup_wait)) begin
            state <= st_boot_load_cmd;
          end else begin
            flash_counter <= flash_counter + 32'd1;
          end
        end
        st_boot_load_cmd: begin
          flash_cs <= 1'b0;
          flash_shift <= {flash_read_cmd, 16'd0};
          flash_bits <= 5'd8;
          return_state <= st_boot_load_address;
          state <= st_boot_send;
        end
        st_boot_load_address: begin
          flash_shift <= 24'd0;  // image starts at flash address 0
          flash_bits <= 5'd24;
          return_state <= st_boot_read_data;
          state <= st_boot_send;
        end
        st_boot_send: begin
          if (!flash_phase) begin
            flash_clk <= 1'b0;
            flash_mosi <= flash_shift[23];  // msb first
            flash_shift <= {flash_shift[22:0], 1'b0};
            flash_bits <= flash_bits - 5'd1;
            flash_phase <= 1'b1;
          end else begin
            flash_clk <= 1'b1;
            flash_phase <= 1'b0;
            if (flash_bits == 5'd0) begin
              state <= return_state;
            end
          end
        end
        st_boot_read_data: begin
          if (!flash_phase) begin
            flash_clk <= 1'b0;
            flash_phase <= 1'b1;
          end else begin
            flash_clk <= 1'b1;  // sample on the rising edge
            flash_phase <= 1'b0;
            flash_byte <= {flash_byte[6:0], flash_miso};
            flash_bits <= flash_bits + 5'd1;
            if (flash_bits == 5'd7) begin
              flash_bits <= 5'd0;
              flash_data[byte_num] <= {flash_byte[6:0], flash_miso};
              byte_num <= byte_num + 2'd1;  // wraps to 0 after each word
              if (byte_num == 2'd3) begin
                state <= st_boot_start_write;
              end
            end
          end
        end
        st_boot_start_write: begin
          if (!busy) begin
            enable <= 1'b1;
            write_type <= wr_word;
            read_type <= rd_none;
            address <= address_next;
            data_in <= {flash_data[3], flash_data[2], flash_data[1], flash_data[0]};
            address_next <= address_next + 32'd4;
            state <= st_boot_write;
          end
        end
        st_boot_write: begin
          if (busy) begin  // write in progress, RAM free next cycle
            if (address_next < 32'(boot_bytes)) begin
              state <= st_boot_read_data;
            end else begin
              flash_cs <= 1'b1;
              enable <= 1'b1;
              write_type <= wr_none;
              read_type <= rd_word;
              address <= 32'd0;
              pc <= 32'd0;
              state <= st_cpu_fetch;
            end
          end
        end
        st_cpu_fetch: begin
          if (data_out_ready) begin
            ir <= data_out;
            state <= st_cpu_execute;
          end
        end
        st_cpu_execute: begin
          // default is fetching pc + 4
          enable <= 1'b1;
          write_type <= wr_none;
          read_type <= rd_word;
          address <= pc + 32'd4;
          pc <= pc + 32'd4;
          state <= st_cpu_fetch;
          unique case (opcode)
            opc_lui: begin
              rd_wd <= imm_u;
              rd_we <= 1'b1;
            end
            opc_auipc: begin
              rd_wd <= pc + imm_u;
              rd_we <= 1'b1;
            end
            opc_imm, opc_reg: begin
              rd_wd <= alu_out;
              rd_we <= 1'b1;
            end
            opc_jal: begin
              rd_wd <= pc + 32'd4;
              rd_we <= 1'b1;
              address <= pc + imm_j;
              pc <= pc + imm_j;
            end
            opc_jalr: begin
              rd_wd <= pc + 32'd4;
              rd_we <= 1'b1;
              address <= jalr_target;
              pc <= jalr_target;
            end
            opc_branch: begin
              if (take_branch) begin
                address <= pc + imm_b;
                pc <= pc + imm_b;
              end
            end
            opc_load: begin
              if (load_type != rd_none) begin
                read_type <= load_type;
                address <= rs1_dat + imm_i;
                state <= st_cpu_load;
              end
            end
            opc_store: begin
              if (store_type != wr_none) begin
                read_type <= rd_none;
                write_type <= store_type;
                address <= rs1_dat + imm_s;
                data_in <= rs2_dat;  // RAM moves it to the right lanes
                state <= st_cpu_store;
              end
            end
            default: ;
          endcase
        end
        st_cpu_store: begin
          // busy marks the write cycle, so the fetch lands just after it
          if (busy) begin
            enable <= 1'b1;
            write_type <= wr_none;
            read_type <= rd_word;
            address <= pc;
            state <= st_cpu_fetch;
          end
        end
        st_cpu_load: begin
          if (data_out_ready) begin
            rd_wd <= data_out;  // already extended by the RAM
            rd_we <= 1'b1;
            state <= st_cpu_load_done;
          end
        end
        st_cpu_load_done: begin
          enable <= 1'b1;
          write_type <= wr_none;
          read_type <= rd_word;
          address <= pc;
          state <= st_cpu_fetch;
        end
      endcase
    end
  end

  rv_regfile i_rv_regfile (
    .clk    (clk),
    .rs1    (rs1),
    .rs2    (rs2),
    .rd     (rd),
    .rd_wd  (rd_wd),
    .rd_we  (rd_we),
    .rs1_dat(rs1_dat),
    .rs2_dat(rs2_dat)
  );

  assign in_cpu = state inside {st_cpu_fetch, st_cpu_execute, st_cpu_store, st_cpu_load,
                                st_cpu_load_done};

  a_state_onehot : assert property (@(posedge clk) disable iff (!rst_n) $onehot(state))
    else $error("core state not one-hot: %b", state);

  a_no_enable_when_busy : assert property (@(posedge clk) disable iff (!rst_n)
    !(enable && busy))
    else $error("RAM request while busy");

  a_flash_released : assert property (@(posedge clk) disable iff (!rst_n)
    in_cpu |=> in_cpu && flash_cs)
    else $error("flash selected after boot");

endmodule

//--- src/rv_ramio.sv
// Word RAM with sized access plus the io_out register at io_addr.
// ram_words must be a power of two; addresses beyond it wrap onto RAM.
// Misaligned accesses are not trapped.
`timescale 1ns/1ps

module rv_ramio #(
  parameter int ram_words = 1024
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable,
  input  rv_soc_pkg::wr_size_e write_type,
  input  rv_soc_pkg::rd_size_e read_type,
  input  logic [31:0]          address,
  input  logic [31:0]          data_in,
  output logic [31:0]          data_out,
  output logic                 data_out_ready,
  output logic                 busy,
  output logic [31:0]          io_out
);
  import rv_soc_pkg::*;

  localparam int aw = $clog2(ram_words);

  logic [31:0] mem [ram_words];
  logic [aw-1:0] word_idx;
  logic is_io;
  logic [3:0] wr_mask;
  logic [31:0] wr_data;
  logic [31:0] rd_word;  // raw word captured on read accept
  logic [1:0] rd_off;
  rd_size_e rd_kind;
  logic [31:0] shifted;

  assign word_idx = address[aw+1:2];
  assign is_io = (address == io_addr);
  assign wr_data = data_in << {address[1:0], 3'b000};  // move into its byte lanes

  always_comb begin
    unique case (write_type)
      wr_byte: wr_mask = 4'b0001 << address[1:0];
      wr_half: wr_mask = 4'b0011 << address[1:0];
      wr_word: wr_mask = 4'b1111;
      default: wr_mask = 4'b0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (enable) begin
      rd_word <= is_io ? io_out : mem[word_idx];
      rd_off  <= address[1:0];
      rd_kind <= read_type;
      for (int i = 0; i < 4; i++) begin
        if (wr_mask[i] && !is_io) begin
          mem[word_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      data_out_ready <= 1'b0;
      io_out <= 32'd0;
    end else begin
      busy <= enable && (write_type != wr_none);  // write cycle
      data_out_ready <= enable && (read_type != rd_none);
      for (int i = 0; i < 4; i++) begin
        if (enable && is_io && wr_mask[i]) begin
          io_out[i*8 +: 8] <= wr_data[i*8 +: 8];
        end
      end
    end
  end

  // pick the addressed lane and extend it
  assign shifted = rd_word >> {rd_off, 3'b000};

  always_comb begin
    unique case (rd_kind[1:0])
      2'b01:   data_out = {{24{rd_kind[2] & shifted[7]}}, shifted[7:0]};
      2'b10:   data_out = {{16{rd_kind[2] & shifted[15]}}, shifted[15:0]};
      default: data_out = shifted;
    endcase
  end

  a_one_request_kind : assert property (@(posedge clk) disable iff (!rst_n)
    enable |-> (write_type == wr_none || read_type == rd_none))
    else $error("read and write requested in the same cycle");

  a_half_aligned : assert property (@(posedge clk) disable iff (!rst_n)
    enable && (write_type == wr_half || read_type[1:0] == 2'b10) |-> !address[0])
    else $error("misaligned half-word access at %h", address);

endmodule

//--- src/rv_regfile.sv
// 32 x 32 register file, combinational reads, write on the clock edge.
// x0 reads as zero and ignores writes.
`timescale 1ns/1ps

module rv_regfile (
  input  logic        clk,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic [31:0] rd_wd,
  input  logic        rd_we,
  output logic [31:0] rs1_dat,
  output logic [31:0] rs2_dat
);

  logic [31:0] regs [1:31];  // no storage for x0

  always_ff @(posedge clk) begin
    if (rd_we && rd != 5'd0) begin
      regs[rd] <= rd_wd;
    end
  end

  assign rs1_dat = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rs2_dat = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

//--- src/rv_soc.sv
// RV32I SoC top: core with boot loader, RAM/IO block, SPI flash pins outward.
// boot_bytes must not exceed 4 * ram_words; software reports through io_out.
`timescale 1ns/1ps

module rv_soc #(
  parameter int startup_wait = 1000,
  parameter int boot_bytes   = 1024,
  parameter int ram_words    = 1024
) (
  input  logic        clk,
  input  logic        rst_n,
  output logic        flash_clk,
  output logic        flash_cs,
  output logic        flash_mosi,
  input  logic        flash_miso,
  output logic [31:0] io_out
);
  import rv_soc_pkg::*;

  logic        enable;
  wr_size_e    write_type;
  rd_size_e    read_type;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;

  rv_core #(
    .startup_wait(startup_wait),
    .boot_bytes  (boot_bytes)
  ) i_rv_core (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .write_type    (write_type),
    .read_type     (read_type),
    .address       (address),
    .data_in       (data_in),
    .data_out      (data_out),
    .data_out_ready(data_out_ready),
    .busy          (busy),
    .flash_clk     (flash_clk),
    .flash_cs      (flash_cs),
    .flash_mosi    (flash_mosi),
    .flash_miso    (flash_miso)
  );

  rv_ramio #(
    .ram_words(ram_words)
  ) i_rv_ramio (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .write_type    (write_type),
    .read_type     (read_type),
    .address       (address),
    .data_in       (data_in),
    .data_out      (data_out),
    .data_out_ready(data_out_ready),
    .busy          (busy),
    .io_out        (io_out)
  );

endmodule

//--- src/rv_soc_pkg.sv
// Shared encodings for the RV32I SoC core and RAM/IO block.
// Read size: bit 2 selects sign extension, bits 1:0 select byte, half or word.

package rv_soc_pkg;

  // major opcodes handled by the core, everything else is a no-op
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_imm    = 7'b0010011,
    opc_reg    = 7'b0110011
  } opcode_e;

  // boot loader and cpu states, one-hot
  typedef enum logic [11:0] {
    st_boot_init_power   = 12'b0000_0000_0001,
    st_boot_load_cmd     = 12'b0000_0000_0010,
    st_boot_send         = 12'b0000_0000_0100,
    st_boot_load_address = 12'b0000_0000_1000,
    st_boot_read_data    = 12'b0000_0001_0000,
    st_boot_start_write  = 12'b0000_0010_0000,
    st_boot_write        = 12'b0000_0100_0000,
    st_cpu_fetch         = 12'b0000_1000_0000,
    st_cpu_execute       = 12'b0001_0000_0000,
    st_cpu_store         = 12'b0010_0000_0000,
    st_cpu_load          = 12'b0100_0000_0000,
    st_cpu_load_done     = 12'b1000_0000_0000
  } core_state_e;

  typedef enum logic [1:0] {
    wr_none = 2'b00,
    wr_byte = 2'b01,
    wr_half = 2'b10,
    wr_word = 2'b11
  } wr_size_e;

  typedef enum logic [2:0] {
    rd_none   = 3'b000,
    rd_byte_u = 3'b001,
    rd_half_u = 3'b010,
    rd_byte_s = 3'b101,
    rd_half_s = 3'b110,
    rd_word   = 3'b111
  } rd_size_e;

  // top word of the address space is the output register
  localparam logic [31:0] io_addr = 32'hffff_fffc;

  localparam logic [7:0] flash_read_cmd = 8'h03;  // plain read, 24-bit address

endpackage

//--- verif/spi_flash_model.sv
// SPI flash read model for command 3 with a 24-bit address and data msb first.
// Bytes come out of each image word little-endian; reads past the image return ff.
`timescale 1ns/1ps

module spi_flash_model #(
  parameter int words = 64
) (
  input  logic flash_clk,
  input  logic flash_cs,
  input  logic flash_mosi,
  output logic flash_miso
);
  import rv_soc_pkg::*;

  logic [31:0] mem [words];  // loaded by the testbench
  logic [31:0] cmd_addr;
  int rx_bits;
  int tx_bit;

  function automatic logic [7:0] image_byte(input logic [23:0] addr);
    if (addr / 4 >= words) begin
      return 8'hff;
    end
    return mem[addr / 4][8 * (addr % 4) +: 8];
  endfunction

  initial begin
    flash_miso = 1'b0;
  end

  always @(posedge flash_cs) begin
    rx_bits <= 0;  // new transaction
    tx_bit <= 0;
  end

  // command and address shift in on the rising edge
  always @(posedge flash_clk) begin
    if (!flash_cs && rx_bits < 32) begin
      cmd_addr <= {cmd_addr[30:0], flash_mosi};
      rx_bits <= rx_bits + 1;
    end
  end

  // data changes while the clock is low
  always @(negedge flash_clk) begin
    logic [7:0] tx_byte;
    if (flash_cs === 1'b0 && rx_bits == 32 && cmd_addr[31:24] == flash_read_cmd) begin
      tx_byte = image_byte(cmd_addr[23:0] + 24'(tx_bit / 8));
      flash_miso <= tx_byte[7 - tx_bit % 8];
      tx_bit <= tx_bit + 1;
    end
  end

endmodule

//--- verif/tb_clk_gen.sv
// Clock and active-low reset for the testbench; reset releases on a rising edge.
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int half_period = 5,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;  // released on the rising edge
  end

endmodule

//--- verif/tb_rv_soc.sv
// Boots a generated program through the flash model and checks the order of io_out
// changes against an instruction-set model; cycle timing of io_out is not checked.
`timescale 1ns/1ps

module tb_rv_soc;
  import rv_soc_pkg::*;

  localparam int startup_wait = 20;
  localparam int boot_bytes = 256;
  localparam int ram_words = 256;
  localparam int image_words = boot_bytes / 4;
  localparam int block_at = 48;  // word index of the branch subroutine

  logic clk;
  logic rst_n;
  logic flash_clk;
  logic flash_cs;
  logic flash_mosi;
  logic flash_miso;
  logic [31:0] io_out;

  logic [31:0] image [image_words];
  string test_name [image_words];  // names the io store at each word
  logic [31:0] exp_val [$];
  string exp_name [$];
  int wr_idx;
  int model_steps;
  int seen;
  int pass_cnt;
  int fail_cnt;
  bit model_ready;
  bit checks_done;

  tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

  spi_flash_model #(.words(image_words)) i_flash (
    .flash_clk (flash_clk),
    .flash_cs  (flash_cs),
    .flash_mosi(flash_mosi),
    .flash_miso(flash_miso)
  );

  rv_soc #(
    .startup_wait(startup_wait),
    .boot_bytes  (boot_bytes),
    .ram_words   (ram_words)
  ) i_rv_soc (
    .clk       (clk),
    .rst_n     (rst_n),
    .flash_clk (flash_clk),
    .flash_cs  (flash_cs),
    .flash_mosi(flash_mosi),
    .flash_miso(flash_miso),
    .io_out    (io_out)
  );

  function automatic logic [31:0] r_insn(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_reg};
  endfunction

  function automatic logic [31:0] i_insn(input logic [31:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input opcode_e op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_insn(input logic [31:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] b_insn(input logic [31:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
  endfunction

  function automatic logic [31:0] u_insn(input logic [19:0] imm, input logic [4:0] rd,
                                         input opcode_e op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_insn(input logic [31:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
  endfunction

  function automatic void emit(input logic [31:0] instr);
    image[wr_idx] = instr;
    wr_idx++;
  endfunction

  function automatic void store_to_io(input logic [4:0] rs, input string name);
    test_name[wr_idx] = name;
    emit(s_insn(-4, rs, 0, 3'd2));  // sw rs, -4(x0) hits io_addr
  endfunction

  function automatic void build_image(input logic [31:0] ra, input logic [31:0] rb);
    logic [31:0] bits;
    wr_idx = 0;
    emit(i_insn(252, 0, 3'd2, 1, opc_load));  // lw x1 from the last image word
    store_to_io(1, "boot_copy");
    emit(u_insn(20'((ra + 32'h800) >> 12), 2, opc_lui));
    emit(i_insn(ra, 2, 3'd0, 2, opc_imm));
    emit(u_insn(20'((rb + 32'h800) >> 12), 3, opc_lui));
    emit(i_insn(rb, 3, 3'd0, 3, opc_imm));
    emit(r_insn(7'h00, 3, 2, 3'd0, 5));  // add
    emit(i_insn(32'h5a5, 5, 3'd4, 5, opc_imm));  // xori
    store_to_io(5, "add_xori");
    emit(r_insn(7'h20, 3, 2, 3'd0, 5));  // sub
    emit(i_insn(-16, 5, 3'd7, 5, opc_imm));  // andi
    store_to_io(5, "sub_andi");
    emit(r_insn(7'h00, 3, 2, 3'd1, 5));  // sll
    emit(i_insn(32'h407, 5, 3'd5, 5, opc_imm));  // srai 7
    store_to_io(5, "sll_srai");
    emit(r_insn(7'h20, 3, 2, 3'd5, 5));  // sra
    emit(i_insn(1, 5, 3'd5, 5, opc_imm));  // srli 1
    store_to_io(5, "sra_srli");
    emit(r_insn(7'h00, 3, 2, 3'd3, 5));  // sltu
    emit(r_insn(7'h00, 3, 2, 3'd2, 7));  // slt
    store_to_io(5, "sltu");
    store_to_io(7, "slt");
    emit(s_insn(512, 2, 0, 3'd2));  // sw
    emit(s_insn(513, 3, 0, 3'd0));  // sb
    emit(s_insn(518, 3, 0, 3'd1));  // sh
    emit(i_insn(513, 0, 3'd0, 5, opc_load));
    store_to_io(5, "lb_513");
    emit(i_insn(513, 0, 3'd4, 5, opc_load));
    store_to_io(5, "lbu_513");
    emit(i_insn(514, 0, 3'd1, 5, opc_load));
    store_to_io(5, "lh_514");
    emit(i_insn(518, 0, 3'd5, 5, opc_load));
    store_to_io(5, "lhu_518");
    emit(i_insn(512, 0, 3'd2, 5, opc_load));
    store_to_io(5, "lw_512");
    emit(r_insn(7'h00, 3, 2, 3'd0, 0));  // add into x0
    store_to_io(0, "x0_write");
    emit(u_insn(20'h12345, 8, opc_auipc));
    store_to_io(8, "auipc");
    emit(i_insn(1, 0, 3'd0, 11, opc_imm));
    emit(i_insn(-1, 0, 3'd0, 12, opc_imm));
    emit(j_insn((block_at - wr_idx) * 4, 15));  // pass (1, -1)
    emit(r_insn(7'h20, 11, 0, 3'd0, 11));
    emit(j_insn((block_at - wr_idx) * 4, 15));  // pass (-1, -1)
    emit(r_insn(7'h20, 12, 0, 3'd0, 12));
    emit(j_insn((block_at - wr_idx) * 4, 15));  // pass (-1, 1)
    store_to_io(16, "jalr_link");
    emit(j_insn(0, 0));  // halt loop
    // branch block sets x6 to the link plus one bit per branch that falls through
    emit(i_insn(0, 15, 3'd0, 6, opc_imm));
    bits = 1;
    foreach (image[k]) begin
      if (k < 6) begin
        emit(b_insn(8, 12, 11, (k < 2) ? 3'(k) : 3'(k + 2)));
        emit(i_insn(bits, 6, 3'd0, 6, opc_imm));
        bits = bits << 1;
      end
    end
    store_to_io(6, "branch_path");
    emit(i_insn(0, 15, 3'd0, 16, opc_jalr));  // jalr x16, 0(x15)
    image[image_words - 1] = 32'h5ac3_9e17;  // boot constant
  endfunction

  // instruction-set model that records every change of the io register
  function automatic void run_model();
    logic [31:0] x [32];
    logic [31:0] ram [ram_words];
    logic [31:0] pc;
    logic [31:0] ir;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] npc;
    logic [31:0] io;
    logic [31:0] sh;
    logic [2:0] f3;
    logic [4:0] rd;
    bit wr;
    bit take;
    bit is_io;
    bit halt;
    int steps;
    foreach (x[i]) x[i] = 32'd0;
    foreach (ram[i]) ram[i] = (i < image_words) ? image[i] : 32'd0;
    pc = 0;
    io = 0;
    halt = 0;
    steps = 0;
    while (!halt && steps < 10000) begin
      ir = ram[(pc >> 2) & (ram_words - 1)];
      f3 = ir[14:12];
      rd = ir[11:7];
      a = x[ir[19:15]];
      b = x[ir[24:20]];
      npc = pc + 4;
      wr = 0;
      res = 0;
      case (ir[6:0])
        opc_lui: begin
          res = {ir[31:12], 12'd0};
          wr = 1;
        end
        opc_auipc: begin
          res = pc + {ir[31:12], 12'd0};
          wr = 1;
        end
        opc_jal: begin
          res = pc + 4;
          wr = 1;
          npc = pc + {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
        end
        opc_jalr: begin
          res = pc + 4;
          wr = 1;
          npc = (a + {{20{ir[31]}}, ir[31:20]}) & ~32'd1;
        end
        opc_branch: begin
          case (f3)
            3'd0: take = (a == b);
            3'd1: take = (a != b);
            3'd4: take = $signed(a) < $signed(b);
            3'd5: take = $signed(a) >= $signed(b);
            3'd6: take = a < b;
            3'd7: take = a >= b;
            default: take = 0;
          endcase
          if (take) begin
            npc = pc + {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
          end
        end
        opc_load: begin
          addr = a + {{20{ir[31]}}, ir[31:20]};
          word = (addr[31:2] == io_addr[31:2]) ? io : ram[(addr >> 2) & (ram_words - 1)];
          sh = word >> (8 * addr[1:0]);
          wr = 1;
          case (f3)
            3'd0: res = {{24{sh[7]}}, sh[7:0]};
            3'd1: res = {{16{sh[15]}}, sh[15:0]};
            3'd4: res = {24'd0, sh[7:0]};
            3'd5: res = {16'd0, sh[15:0]};
            3'd2: res = word;
            default: wr = 0;
          endcase
        end
        opc_store: begin
          addr = a + {{20{ir[31]}}, ir[31:25], ir[11:7]};
          is_io = (addr[31:2] == io_addr[31:2]);
          word = is_io ? io : ram[(addr >> 2) & (ram_words - 1)];
          case (f3)
            3'd0: word[8 * addr[1:0] +: 8] = b[7:0];
            3'd1: word[16 * addr[1] +: 16] = b[15:0];
            3'd2: word = b;
            default: ;
          endcase
          if (!is_io) begin
            ram[(addr >> 2) & (ram_words - 1)] = word;
          end else if (word != io) begin
            io = word;  // only changes are visible on io_out
            exp_val.push_back(io);
            exp_name.push_back(test_name[(pc >> 2) % image_words]);
          end
        end
        opc_imm, opc_reg: begin
          if (ir[6:0] == opc_imm) begin
            b = {{20{ir[31]}}, ir[31:20]};
          end
          wr = 1;
          case (f3)
            3'd0: res = (ir[6:0] == opc_reg && ir[30]) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: res = ir[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: res = a | b;
            default: res = a & b;
          endcase
        end
        default: ;
      endcase
      if (wr && rd != 0) begin
        x[rd] = res;
      end
      halt = (npc == pc);
      pc = npc;
      steps++;
    end
    model_steps = steps;
  endfunction

  initial begin
    logic [31:0] ra;
    logic [31:0] rb;
    void'($urandom(32'hf6c1));
    ra = $urandom();
    rb = $urandom();
    ra[31] = 1'b1;  // negative so sra and srai fill with ones
    rb[31] = 1'b0;  // slt and sltu give different results
    rb[7] = 1'b1;  // lb and lbu differ
    rb[0] = 1'b1;  // nonzero shift amount
    build_image(ra, rb);
    foreach (image[i]) i_flash.mem[i] = image[i];
    run_model();
    $display("operands %h %h, %0d instructions, %0d io values expected",
             ra, rb, model_steps, exp_val.size());
    model_ready = 1;
    wait (checks_done);
    repeat (20) @(posedge clk);  // any late io_out change shows up as unexpected
    $display("%0d tests passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // compares each io_out change with the next model value
  initial begin
    logic [31:0] last;
    last = 32'd0;
    wait (model_ready && rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (io_out !== last) begin
        if (seen >= exp_val.size()) begin
          $display("io_out changed to %h after the last expected value", io_out);
          fail_cnt++;
        end else if (io_out !== exp_val[seen]) begin
          $display("Error: test %s expected %h actual %h", exp_name[seen], exp_val[seen],
                   io_out);
          fail_cnt++;
        end else begin
          $display("test %s ok: expected %h actual %h", exp_name[seen], exp_val[seen],
                   io_out);
          pass_cnt++;
        end
        last = io_out;
        seen++;
        if (seen == exp_val.size()) begin
          checks_done = 1;
        end
      end
    end
  end

  // watchdog sized from boot length and model instruction count with a 2x margin
  initial begin
    int limit;
    wait (model_ready);
    limit = 2 * (startup_wait + 64 * image_words + 6 * model_steps);
    repeat (limit) @(posedge clk);
    $display("Timeout: only %0d of %0d io values seen after %0d cycles", seen,
             exp_val.size(), limit);
    $display("Test failed");
    $finish;
  end

endmodule
